/* files.f */
+incdir+test
hdl/link_bus_pkg.sv
hdl/id_remap_pkg.sv
hdl/rr_arbiter.sv
hdl/read_mux.sv
hdl/id_remap.sv
hdl/link_read_top.sv
test/tb_link_read.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f files.f --top-module tb_link_read

out=$(./obj_dir/Vtb_link_read)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

/* test/tb_link_tasks.svh */
//////////////////////////////////////////////////
// Checks and scoreboard
//////////////////////////////////////////////////

task automatic check_val(input string name, input logic [35:0] got, input logic [35:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_true(input logic cond, input string what);
  checks++;
  assert (cond) else begin
    errors++;
    $display("Check failed: %s", what);
  end
endtask

// Oldest outstanding read of port p must match
task automatic match_rsp(input int p, input slv_id_t id, input data_t data);
  int idx;
  idx = -1;
  for (int i = 0; i < exp_q.size(); i++) begin
    if (idx < 0 && exp_q[i][35:34] == port_idx_t'(p)) begin
      idx = i;
    end
  end
  check_true(idx >= 0, $sformatf("response on port %0d with no read outstanding", p));
  if (idx >= 0) begin
    check_val($sformatf("slv_rsp_id_o[%0d]", p), id, exp_q[idx][33:32]);
    check_val($sformatf("slv_rsp_data_o[%0d]", p), data, exp_q[idx][31:0]);
    exp_q.delete(idx);
  end
endtask

//////////////////////////////////////////////////
// Drivers and waits
//////////////////////////////////////////////////

task automatic drive_req(input int p, input slv_id_t id, input addr_t addr);
  slv_req_valid[p] <= 1'b1;
  slv_req_id[p]    <= id;
  slv_req_addr[p]  <= addr;
endtask

task automatic wait_accept(input int p, output mst_id_t narrow);
  int   cnt;
  logic done;
  cnt    = 0;
  done   = 1'b0;
  narrow = '0;
  while (!done && cnt < TIMEOUT) begin
    @(negedge periph_clk);
    cnt++;
    if (slv_req_valid[p] && slv_req_ready[p]) begin
      done   = 1'b1;
      narrow = mst_req_id; // Master side moves in the same cycle
      check_val("mst_req_addr_o", mst_req_addr, slv_req_addr[p]);
      exp_q.push_back({port_idx_t'(p), slv_req_id[p], slv_req_addr[p] ^ RSP_XOR});
      accept_order.push_back(p);
    end
  end
  if (!done) begin
    timeouts++;
    $display("Timeout: the request on port %0d was never accepted", p);
  end
  @(posedge periph_clk);
  slv_req_valid[p] <= 1'b0;
endtask

task automatic wait_drain();
  int cnt;
  cnt = 0;
  while (exp_q.size() != 0 && cnt < TIMEOUT) begin
    @(negedge periph_clk);
    cnt++;
  end
  if (exp_q.size() != 0) begin
    timeouts++;
    $display("Timeout: %0d reads never got their response", exp_q.size());
    exp_q.delete();
  end
endtask

// Fixed observation window while a request must stay blocked
task automatic check_stall(input int p, input int cycles);
  repeat (cycles) begin
    @(negedge periph_clk);
    check_val($sformatf("slv_req_ready_o[%0d]", p), slv_req_ready[p], 0);
    check_val("mst_req_valid_o", mst_req_valid, 0);
  end
endtask

// Response offered on the master side while its target port is busy
task automatic check_rsp_blocked(input int cycles);
  int cnt;
  cnt = 0;
  while (!mst_rsp_valid && cnt < TIMEOUT) begin
    @(negedge periph_clk);
    cnt++;
  end
  if (!mst_rsp_valid) begin
    timeouts++;
    $display("Timeout: no response was offered on the master side");
  end
  repeat (cycles) begin
    check_val("mst_rsp_ready_o", mst_rsp_ready, 0);
    @(negedge periph_clk);
  end
endtask

task automatic hold_rsp();
  @(posedge periph_clk);
  rsp_hold  <= 1'b1;
  rsp_allow <= rsp_used;
endtask

task automatic release_rsp(input int n);
  @(posedge periph_clk);
  rsp_allow <= rsp_allow + n;
endtask

task automatic apply_reset();
  @(posedge periph_clk);
  reset_i <= 1'b1;
  repeat (5) @(posedge periph_clk);
  reset_i <= 1'b0;
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_single_reads();
  mst_id_t narrow;
  $display("Test: single read per port");
  for (int p = 0; p < NUM_PORTS; p++) begin
    @(posedge periph_clk);
    drive_req(p, slv_id_t'(p), addr_t'(32'h4000_0010 + p * 32'h104));
    wait_accept(p, narrow);
    wait_drain();
  end
endtask

task automatic test_concurrent();
  mst_id_t n0, n1, n2, n3;
  $display("Test: concurrent requests");
  accept_order.delete();
  @(posedge periph_clk);
  for (int p = 0; p < NUM_PORTS; p++) begin
    drive_req(p, slv_id_t'(NUM_PORTS - 1 - p), addr_t'(32'h8000_003C + (p << 8)));
  end
  fork
    wait_accept(0, n0);
    wait_accept(1, n1);
    wait_accept(2, n2);
    wait_accept(3, n3);
  join
  check_val("accepted requests", accept_order.size(), NUM_PORTS);
  wait_drain();
endtask

task automatic test_id_reuse();
  mst_id_t n_a, n_b;
  $display("Test: narrow ID reuse");
  hold_rsp();
  @(posedge periph_clk);
  drive_req(1, 2'd2, 32'h0000_1200);
  wait_accept(1, n_a);
  @(posedge periph_clk);
  drive_req(1, 2'd2, 32'h0000_1240);
  wait_accept(1, n_b);
  check_val("mst_req_id_o", n_b, n_a); // Same wide ID, same slot
  @(posedge periph_clk);
  slv_rsp_ready[1] <= 1'b0; // Port 1 busy, its responses must wait
  rsp_hold         <= 1'b0;
  check_rsp_blocked(4);
  @(posedge periph_clk);
  slv_rsp_ready[1] <= 1'b1;
  wait_drain();
endtask

task automatic test_table_full();
  mst_id_t narrow;
  $display("Test: table-full stall");
  @(posedge periph_clk);
  rdy_force <= 1'b1;
  hold_rsp();
  for (int p = 0; p < NUM_PORTS; p++) begin
    @(posedge periph_clk);
    drive_req(p, 2'd0, addr_t'(32'h2000_0000 + p * 4));
    wait_accept(p, narrow);
    check_val("mst_req_id_o", narrow, p); // Lowest free slot
  end
  @(posedge periph_clk);
  drive_req(0, 2'd1, 32'h2000_0100);
  check_stall(0, 12);
  release_rsp(1);
  wait_accept(0, narrow);
  check_val("mst_req_id_o", narrow, 0); // Slot 0 freed by its only read
  @(posedge periph_clk);
  rsp_hold <= 1'b0;
  wait_drain();
endtask

task automatic test_id_limit();
  mst_id_t narrow;
  $display("Test: per-ID limit");
  hold_rsp();
  for (int k = 0; k < MAX_TXNS_PER_ID; k++) begin
    @(posedge periph_clk);
    drive_req(2, 2'd3, addr_t'(32'h3000_0000 + k * 8));
    wait_accept(2, narrow);
    check_val("mst_req_id_o", narrow, 0);
  end
  @(posedge periph_clk);
  drive_req(2, 2'd3, 32'h3000_0040);
  check_stall(2, 12);
  release_rsp(1);
  wait_accept(2, narrow);
  check_val("mst_req_id_o", narrow, 0);
  @(posedge periph_clk);
  rsp_hold <= 1'b0;
  wait_drain();
endtask

task automatic test_reset_state();
  mst_id_t n0, n1, n2, n3;
  $display("Test: reset state");
  apply_reset();
  @(negedge periph_clk);
  check_val("mst_req_valid_o", mst_req_valid, 0);
  check_val("slv_rsp_valid_o", slv_rsp_valid, 0);
  accept_order.delete();
  @(posedge periph_clk);
  for (int p = 0; p < NUM_PORTS; p++) begin
    drive_req(p, slv_id_t'(p), addr_t'(32'h5000_0000 + p * 16));
  end
  fork
    wait_accept(0, n0);
    wait_accept(1, n1);
    wait_accept(2, n2);
    wait_accept(3, n3);
  join
  check_val("accepted requests", accept_order.size(), NUM_PORTS);
  for (int k = 0; k < accept_order.size(); k++) begin
    check_val($sformatf("grant order %0d", k), accept_order[k], k); // Pointer starts at 0
  end
  wait_drain();
endtask

/* test/tb_link_read.sv */
`timescale 1ns/1ps

module tb_link_read;

  import link_bus_pkg::*;
  import id_remap_pkg::*;

  localparam int    TIMEOUT = 200;          // Cycles allowed per wait
  localparam data_t RSP_XOR = 32'hA5A5A5A5; // Responder data pattern

  logic                    periph_clk = 1'b0;
  logic                    reset_i;
  logic [NUM_PORTS-1:0]    slv_req_valid;
  logic [NUM_PORTS-1:0]    slv_req_ready;
  slv_id_t [NUM_PORTS-1:0] slv_req_id;
  addr_t   [NUM_PORTS-1:0] slv_req_addr;
  logic [NUM_PORTS-1:0]    slv_rsp_valid;
  slv_id_t [NUM_PORTS-1:0] slv_rsp_id;
  data_t   [NUM_PORTS-1:0] slv_rsp_data;
  logic [NUM_PORTS-1:0]    slv_rsp_ready;
  logic                    mst_req_valid;
  mst_id_t                 mst_req_id;
  addr_t                   mst_req_addr;
  logic                    mst_req_ready = 1'b0;
  logic                    mst_rsp_valid = 1'b0;
  mst_id_t                 mst_rsp_id    = '0;
  data_t                   mst_rsp_data  = '0;
  logic                    mst_rsp_ready;

  logic [35:0] exp_q [$];        // {port, requester ID, data}
  int          accept_order [$]; // Ports in the order their requests went through
  int          checks   = 0;
  int          errors   = 0;
  int          timeouts = 0;

  // Responder state
  logic [33:0] rsp_q [$];        // {narrow ID, data}
  integer      seed      = 78;
  logic        rdy_force = 1'b0; // Master ready stuck high
  logic        rsp_hold  = 1'b0;
  int          rsp_allow = 0;    // Held responses released so far
  int          rsp_used  = 0;
  logic        req_fire  = 1'b0;
  logic        rsp_fire  = 1'b0;
  mux_id_t     req_wide  = '0;   // Port and requester ID of the request moving now
  mux_id_t     nid_owner [MAX_UNIQ_IDS];
  int          nid_cnt   [MAX_UNIQ_IDS]; // Reads outstanding per narrow ID

  always #4 periph_clk = ~periph_clk;

  link_read_top DUT (
    .periph_clk      ( periph_clk    ),
    .reset_i         ( reset_i       ),
    .slv_req_valid_i ( slv_req_valid ),
    .slv_req_ready_o ( slv_req_ready ),
    .slv_req_id_i    ( slv_req_id    ),
    .slv_req_addr_i  ( slv_req_addr  ),
    .slv_rsp_valid_o ( slv_rsp_valid ),
    .slv_rsp_id_o    ( slv_rsp_id    ),
    .slv_rsp_data_o  ( slv_rsp_data  ),
    .slv_rsp_ready_i ( slv_rsp_ready ),
    .mst_req_valid_o ( mst_req_valid ),
    .mst_req_id_o    ( mst_req_id    ),
    .mst_req_addr_o  ( mst_req_addr  ),
    .mst_req_ready_i ( mst_req_ready ),
    .mst_rsp_valid_i ( mst_rsp_valid ),
    .mst_rsp_id_i    ( mst_rsp_id    ),
    .mst_rsp_data_i  ( mst_rsp_data  ),
    .mst_rsp_ready_o ( mst_rsp_ready )
  );

  `include "tb_link_tasks.svh"

  //////////////////////////////////////////////////
  // Responder model
  //////////////////////////////////////////////////

  always @(negedge periph_clk) begin
    req_fire = mst_req_valid && mst_req_ready;
    rsp_fire = mst_rsp_valid && mst_rsp_ready;
    if (reset_i) begin
      rsp_q.delete();
      for (int n = 0; n < MAX_UNIQ_IDS; n++) begin
        nid_cnt[n] = 0;
      end
    end else begin
      if (rsp_fire) begin
        rsp_q.delete(0);
        nid_cnt[mst_rsp_id]--;
      end
      if (req_fire) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (slv_req_valid[p] && slv_req_ready[p]) begin
            req_wide = {port_idx_t'(p), slv_req_id[p]};
          end
        end
        // A narrow ID still in use belongs to one wide ID only
        if (nid_cnt[mst_req_id] != 0) begin
          check_val("wide ID behind mst_req_id_o", req_wide, nid_owner[mst_req_id]);
        end
        nid_owner[mst_req_id] = req_wide;
        nid_cnt[mst_req_id]++;
        rsp_q.push_back({mst_req_id, mst_req_addr ^ RSP_XOR});
      end
    end
  end

  always @(posedge periph_clk) begin
    if (reset_i) begin
      mst_req_ready <= 1'b0;
      mst_rsp_valid <= 1'b0;
    end else begin
      mst_req_ready <= rdy_force || (($random(seed) & 3) != 0); // Busy about one cycle in four
      if (!mst_rsp_valid || rsp_fire) begin
        if (rsp_q.size() != 0 && (!rsp_hold || rsp_used < rsp_allow)) begin
          mst_rsp_valid              <= 1'b1;
          {mst_rsp_id, mst_rsp_data} <= rsp_q[0]; // Oldest first
          if (rsp_hold) begin
            rsp_used <= rsp_used + 1;
          end
        end else begin
          mst_rsp_valid <= 1'b0;
        end
      end
    end
  end

  // Response monitor, one scoreboard for all ports
  always @(negedge periph_clk) begin
    if (!reset_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_rsp_valid[p] && slv_rsp_ready[p]) begin
          match_rsp(p, slv_rsp_id[p], slv_rsp_data[p]);
        end
      end
    end
  end

  initial begin
    reset_i       = 1'b1;
    slv_req_valid = '0;
    slv_req_id    = '0;
    slv_req_addr  = '0;
    slv_rsp_ready = '1;
    repeat (5) @(posedge periph_clk);
    reset_i <= 1'b0;
    test_single_reads();
    test_concurrent();
    test_id_reuse();
    test_table_full();
    test_id_limit();
    test_reset_state();
    repeat (4) @(posedge periph_clk);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* hdl/link_read_top.sv */
`timescale 1ns/1ps

module link_read_top (
  input  logic                                             periph_clk,
  input  logic                                             reset_i,
  // Requester ports
  input  logic                  [link_bus_pkg::NUM_PORTS-1:0] slv_req_valid_i,
  output logic                  [link_bus_pkg::NUM_PORTS-1:0] slv_req_ready_o,
  input  link_bus_pkg::slv_id_t [link_bus_pkg::NUM_PORTS-1:0] slv_req_id_i,
  input  link_bus_pkg::addr_t   [link_bus_pkg::NUM_PORTS-1:0] slv_req_addr_i,
  output logic                  [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_valid_o,
  output link_bus_pkg::slv_id_t [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_id_o,
  output link_bus_pkg::data_t   [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_data_o,
  input  logic                  [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_ready_i,
  // Master port
  output logic                                             mst_req_valid_o,
  output id_remap_pkg::mst_id_t                            mst_req_id_o,
  output link_bus_pkg::addr_t                              mst_req_addr_o,
  input  logic                                             mst_req_ready_i,
  input  logic                                             mst_rsp_valid_i,
  input  id_remap_pkg::mst_id_t                            mst_rsp_id_i,
  input  link_bus_pkg::data_t                              mst_rsp_data_i,
  output logic                                             mst_rsp_ready_o
);

  import link_bus_pkg::*;

  // Wide-ID link between the multiplexer and the remapper
  logic    mux_req_valid;
  mux_id_t mux_req_id;
  addr_t   mux_req_addr;
  logic    mux_req_ready;
  logic    mux_rsp_valid;
  mux_id_t mux_rsp_id;
  data_t   mux_rsp_data;
  logic    mux_rsp_ready;

  read_mux i_read_mux (
    .periph_clk      ( periph_clk      ),
    .reset_i         ( reset_i         ),
    .slv_req_valid_i ( slv_req_valid_i ),
    .slv_req_ready_o ( slv_req_ready_o ),
    .slv_req_id_i    ( slv_req_id_i    ),
    .slv_req_addr_i  ( slv_req_addr_i  ),
    .slv_rsp_valid_o ( slv_rsp_valid_o ),
    .slv_rsp_id_o    ( slv_rsp_id_o    ),
    .slv_rsp_data_o  ( slv_rsp_data_o  ),
    .slv_rsp_ready_i ( slv_rsp_ready_i ),
    .mux_req_valid_o ( mux_req_valid   ),
    .mux_req_id_o    ( mux_req_id      ),
    .mux_req_addr_o  ( mux_req_addr    ),
    .mux_req_ready_i ( mux_req_ready   ),
    .mux_rsp_valid_i ( mux_rsp_valid   ),
    .mux_rsp_id_i    ( mux_rsp_id      ),
    .mux_rsp_data_i  ( mux_rsp_data    ),
    .mux_rsp_ready_o ( mux_rsp_ready   )
  );

  id_remap i_id_remap (
    .periph_clk      ( periph_clk      ),
    .reset_i         ( reset_i         ),
    .slv_req_valid_i ( mux_req_valid   ),
    .slv_req_ready_o ( mux_req_ready   ),
    .slv_req_id_i    ( mux_req_id      ),
    .slv_req_addr_i  ( mux_req_addr    ),
    .slv_rsp_valid_o ( mux_rsp_valid   ),
    .slv_rsp_id_o    ( mux_rsp_id      ),
    .slv_rsp_data_o  ( mux_rsp_data    ),
    .slv_rsp_ready_i ( mux_rsp_ready   ),
    .mst_req_valid_o ( mst_req_valid_o ),
    .mst_req_id_o    ( mst_req_id_o    ),
    .mst_req_addr_o  ( mst_req_addr_o  ),
    .mst_req_ready_i ( mst_req_ready_i ),
    .mst_rsp_valid_i ( mst_rsp_valid_i ),
    .mst_rsp_id_i    ( mst_rsp_id_i    ),
    .mst_rsp_data_i  ( mst_rsp_data_i  ),
    .mst_rsp_ready_o ( mst_rsp_ready_o )
  );

endmodule

/* hdl/id_remap.sv */
`timescale 1ns/1ps

module id_remap (
  input  logic                  periph_clk,
  input  logic                  reset_i,
  // Wide side, towards the multiplexer
  input  logic                  slv_req_valid_i,
  output logic                  slv_req_ready_o,
  input  link_bus_pkg::mux_id_t slv_req_id_i,
  input  link_bus_pkg::addr_t   slv_req_addr_i,
  output logic                  slv_rsp_valid_o,
  output link_bus_pkg::mux_id_t slv_rsp_id_o,
  output link_bus_pkg::data_t   slv_rsp_data_o,
  input  logic                  slv_rsp_ready_i,
  // Narrow side, towards the link
  output logic                  mst_req_valid_o,
  output id_remap_pkg::mst_id_t mst_req_id_o,
  output link_bus_pkg::addr_t   mst_req_addr_o,
  input  logic                  mst_req_ready_i,
  input  logic                  mst_rsp_valid_i,
  input  id_remap_pkg::mst_id_t mst_rsp_id_i,
  input  link_bus_pkg::data_t   mst_rsp_data_i,
  output logic                  mst_rsp_ready_o
);

  import link_bus_pkg::*;
  import id_remap_pkg::*;

  // Remap table
  logic [MAX_UNIQ_IDS-1:0] slot_vld_q;
  mux_id_t                 slot_id_q  [MAX_UNIQ_IDS];
  txn_cnt_t                slot_cnt_q [MAX_UNIQ_IDS];
  txn_cnt_t                cnt_d      [MAX_UNIQ_IDS];

  logic                    match_hit;
  mst_id_t                 match_idx;
  logic                    free_hit;
  mst_id_t                 free_idx;
  mst_id_t                 req_slot;
  logic                    req_room;
  logic                    req_fire;
  logic                    rsp_fire;
  logic [MAX_UNIQ_IDS-1:0] slot_inc;
  logic [MAX_UNIQ_IDS-1:0] slot_dec;

  //////////////////////////////////////////////////
  // Request lookup
  //////////////////////////////////////////////////

  always_comb begin
    match_hit = 1'b0;
    match_idx = '0;
    free_hit  = 1'b0;
    free_idx  = '0;
    for (int unsigned s = 0; s < MAX_UNIQ_IDS; s++) begin
      if (!match_hit && slot_vld_q[s] && (slot_id_q[s] == slv_req_id_i)) begin
        match_hit = 1'b1;
        match_idx = MST_ID_W'(s);
      end
      if (!free_hit && !slot_vld_q[s]) begin // Lowest free slot
        free_hit = 1'b1;
        free_idx = MST_ID_W'(s);
      end
    end
  end

  // Stall when the table is full or the slot has hit its limit
  assign req_room = match_hit ? (slot_cnt_q[match_idx] != CNT_W'(MAX_TXNS_PER_ID))
                              : free_hit;
  assign req_slot = match_hit ? match_idx : free_idx;

  assign mst_req_valid_o = slv_req_valid_i & req_room;
  assign slv_req_ready_o = mst_req_ready_i & req_room;
  assign mst_req_id_o    = req_slot;
  assign mst_req_addr_o  = slv_req_addr_i;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign slv_rsp_id_o    = slot_id_q[mst_rsp_id_i]; // Restore the wide ID
  assign slv_rsp_data_o  = mst_rsp_data_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  //////////////////////////////////////////////////
  // Table update
  //////////////////////////////////////////////////

  assign req_fire = mst_req_valid_o & mst_req_ready_i;
  assign rsp_fire = mst_rsp_valid_i & slv_rsp_ready_i;

  always_comb begin
    for (int unsigned s = 0; s < MAX_UNIQ_IDS; s++) begin
      slot_inc[s] = req_fire && (req_slot == MST_ID_W'(s));
      slot_dec[s] = rsp_fire && (mst_rsp_id_i == MST_ID_W'(s));
      cnt_d[s]    = slot_cnt_q[s] + CNT_W'(slot_inc[s]) - CNT_W'(slot_dec[s]);
    end
  end

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      slot_vld_q <= '0;
      for (int unsigned s = 0; s < MAX_UNIQ_IDS; s++) begin
        slot_cnt_q[s] <= '0;
      end
    end else begin
      for (int unsigned s = 0; s < MAX_UNIQ_IDS; s++) begin
        slot_cnt_q[s] <= cnt_d[s];
        slot_vld_q[s] <= (cnt_d[s] != '0); // Freed at zero
      end
    end
  end

  // Wide ID captured when a slot is allocated
  always_ff @(posedge periph_clk) begin
    for (int unsigned s = 0; s < MAX_UNIQ_IDS; s++) begin
      if (slot_inc[s] && !slot_vld_q[s]) begin
        slot_id_q[s] <= slv_req_id_i;
      end
    end
  end

  rsp_slot_valid: assert property (@(posedge periph_clk) disable iff (reset_i)
    mst_rsp_valid_i |-> slot_vld_q[mst_rsp_id_i])
    else $error("id_remap: response for an unused narrow ID");

  // Next count, taken at full width so a wrap would show
  for (genvar g = 0; g < MAX_UNIQ_IDS; g++) begin : gen_cnt_chk
    cnt_limit: assert property (@(posedge periph_clk) disable iff (reset_i)
      (int'(slot_cnt_q[g]) + int'(slot_inc[g]) - int'(slot_dec[g]))
        <= int'(MAX_TXNS_PER_ID))
      else $error("id_remap: slot %0d over its read limit", g);
  end

endmodule

/* hdl/read_mux.sv */
`timescale 1ns/1ps

module read_mux (
  input  logic                                            periph_clk,
  input  logic                                            reset_i,
  // Requester ports
  input  logic                 [link_bus_pkg::NUM_PORTS-1:0] slv_req_valid_i,
  output logic                 [link_bus_pkg::NUM_PORTS-1:0] slv_req_ready_o,
  input  link_bus_pkg::slv_id_t [link_bus_pkg::NUM_PORTS-1:0] slv_req_id_i,
  input  link_bus_pkg::addr_t   [link_bus_pkg::NUM_PORTS-1:0] slv_req_addr_i,
  output logic                 [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_valid_o,
  output link_bus_pkg::slv_id_t [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_id_o,
  output link_bus_pkg::data_t   [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_data_o,
  input  logic                 [link_bus_pkg::NUM_PORTS-1:0] slv_rsp_ready_i,
  // Merged port
  output logic                                            mux_req_valid_o,
  output link_bus_pkg::mux_id_t                           mux_req_id_o,
  output link_bus_pkg::addr_t                             mux_req_addr_o,
  input  logic                                            mux_req_ready_i,
  input  logic                                            mux_rsp_valid_i,
  input  link_bus_pkg::mux_id_t                           mux_rsp_id_i,
  input  link_bus_pkg::data_t                             mux_rsp_data_i,
  output logic                                            mux_rsp_ready_o
);

  import link_bus_pkg::*;

  logic [NUM_PORTS-1:0] gnt;
  port_idx_t            gnt_idx;
  logic                 req_accept;
  port_idx_t            rsp_port;  // Target port of the response
  slv_id_t              rsp_id;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  rr_arbiter #(
    .NumReq ( NUM_PORTS )
  ) i_rr_arbiter (
    .periph_clk ( periph_clk      ),
    .reset_i    ( reset_i         ),
    .req_i      ( slv_req_valid_i ),
    .accept_i   ( req_accept      ),
    .gnt_o      ( gnt             ),
    .gnt_idx_o  ( gnt_idx         )
  );

  assign mux_req_valid_o = |gnt;
  assign mux_req_id_o    = {gnt_idx, slv_req_id_i[gnt_idx]}; // Prefix the port index
  assign mux_req_addr_o  = slv_req_addr_i[gnt_idx];

  // Only the granted port sees ready
  assign slv_req_ready_o = gnt & {NUM_PORTS{mux_req_ready_i}};
  assign req_accept      = mux_req_valid_o & mux_req_ready_i;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  assign rsp_port = mux_rsp_id_i[MUX_ID_W-1:SLV_ID_W];
  assign rsp_id   = mux_rsp_id_i[SLV_ID_W-1:0];

  always_comb begin
    slv_rsp_valid_o           = '0;
    slv_rsp_valid_o[rsp_port] = mux_rsp_valid_i;
  end

  // Payload goes to every port, valid selects the one that owns it
  assign slv_rsp_id_o   = {NUM_PORTS{rsp_id}};
  assign slv_rsp_data_o = {NUM_PORTS{mux_rsp_data_i}};

  assign mux_rsp_ready_o = slv_rsp_ready_i[rsp_port];

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
  parameter  int unsigned NumReq = 4,
  localparam int unsigned IdxW   = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic              periph_clk,
  input  logic              reset_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              accept_i,
  output logic [NumReq-1:0] gnt_o,
  output logic [IdxW-1:0]   gnt_idx_o
);

  logic [IdxW-1:0] ptr_q;      // First requester looked at
  logic            lock_q;     // Grant pending acceptance
  logic [IdxW-1:0] lock_idx_q;
  logic            win_vld;
  logic [IdxW-1:0] win_idx;
  logic [IdxW-1:0] next_ptr;

  // Winner search, starting at the pointer and wrapping around
  always_comb begin
    int unsigned cand;
    win_vld = 1'b0;
    win_idx = '0;
    cand    = 0;
    if (lock_q) begin
      win_vld = req_i[lock_idx_q]; // Held grant wins
      win_idx = lock_idx_q;
    end else begin
      for (int unsigned k = 0; k < NumReq; k++) begin
        cand = ptr_q + k;
        if (cand >= NumReq) begin
          cand = cand - NumReq;
        end
        if (!win_vld && req_i[cand]) begin
          win_vld = 1'b1;
          win_idx = IdxW'(cand);
        end
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (win_vld) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign gnt_idx_o = win_idx;
  assign next_ptr  = (win_idx == IdxW'(NumReq - 1)) ? '0 : win_idx + 1'b1;

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else if (accept_i) begin
      ptr_q  <= next_ptr; // One past the winner
      lock_q <= 1'b0;
    end else begin
      lock_q <= win_vld;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (win_vld) begin
      lock_idx_q <= win_idx;
    end
  end

  // Grant stays put until the request is accepted or withdrawn
  gnt_hold: assert property (@(posedge periph_clk) disable iff (reset_i)
    (|gnt_o && !accept_i) |=> ((gnt_o == $past(gnt_o)) || !(|gnt_o)))
    else $error("rr_arbiter: grant moved before acceptance");

endmodule

/* hdl/id_remap_pkg.sv */
package id_remap_pkg;

  //////////////////////////////////////////////////
  // Remap table sizing
  //////////////////////////////////////////////////

  // One slot per narrow ID, so the slot index is the narrow ID
  localparam int unsigned MAX_UNIQ_IDS = 4;
  localparam int unsigned MST_ID_W     = $clog2(MAX_UNIQ_IDS);

  // Outstanding reads allowed on one slot
  localparam int unsigned MAX_TXNS_PER_ID = 3;

  // Counter must hold 0 up to MAX_TXNS_PER_ID
  localparam int unsigned CNT_W = $clog2(MAX_TXNS_PER_ID + 1);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [MST_ID_W-1:0] mst_id_t;  // Narrow master-side ID
  typedef logic [CNT_W-1:0]    txn_cnt_t; // Per-slot outstanding count

endpackage

/* hdl/link_bus_pkg.sv */
package link_bus_pkg;

  //////////////////////////////////////////////////
  // Requester ports
  //////////////////////////////////////////////////

  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);

  //////////////////////////////////////////////////
  // ID widths
  //////////////////////////////////////////////////

  localparam int unsigned SLV_ID_W = 2;                     // Requester-side ID
  localparam int unsigned MUX_ID_W = PORT_IDX_W + SLV_ID_W; // Port index on top

  //////////////////////////////////////////////////
  // Payload widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Types for the widths above
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MUX_ID_W-1:0]   mux_id_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;

endpackage
